// ==== Makefile ====
TOP := twiddle_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f vlog.f --top-module $(TOP)
	verilator --lint-only --timescale 1ns/100ps -f vlog.f --top-module twiddle_mul_process

obj_dir/V$(TOP): vlog.f logic/*.sv test/*.sv test/*.svh
	verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/delay_line.sv ====
`default_nettype none

module delay_line #(
    parameter int DEPTH = 1
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire ntt_pkg::data_t d,
    output wire ntt_pkg::data_t q
);

    // taps[0] holds the newest word.
    ntt_pkg::data_t taps [0:DEPTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // word sampled DEPTH edges ago.
    assign q = taps[DEPTH-1];

endmodule

`default_nettype wire

// ==== logic/mod_mul.sv ====
`default_nettype none

module mod_mul (
    input  wire            clk,
    input  wire            rst_n,
    input  wire ntt_pkg::data_t a,
    input  wire ntt_pkg::data_t b,
    input  wire ntt_pkg::data_t n,
    output ntt_pkg::data_t      p
);

    // operands brought below n.
    ntt_pkg::data_t a_red;
    ntt_pkg::data_t b_red;

    // full product of the reduced operands.
    ntt_pkg::prod_t prod;

    // a zero modulus gives zero instead of an undefined remainder.
    function automatic ntt_pkg::data_t reduce_word(
        input ntt_pkg::data_t x,
        input ntt_pkg::data_t m
    );
        if (m == '0) begin
            return '0;
        end
        return x % m;
    endfunction

    function automatic ntt_pkg::data_t reduce_prod(
        input ntt_pkg::prod_t x,
        input ntt_pkg::data_t m
    );
        ntt_pkg::prod_t r;
        if (m == '0) begin
            return '0;
        end
        r = x % ntt_pkg::prod_t'(m);
        return r[ntt_pkg::D_WIDTH-1:0];
    endfunction

    // stage 1, operand reduction.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_red <= '0;
            b_red <= '0;
        end else begin
            a_red <= reduce_word(a, n);
            b_red <= reduce_word(b, n);
        end
    end

    // stage 2, the wide multiply.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod <= '0;
        end else begin
            prod <= ntt_pkg::prod_t'(a_red) * ntt_pkg::prod_t'(b_red);
        end
    end

    // stage 3, fold the product back into one word.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p <= '0;
        end else begin
            p <= reduce_prod(prod, n);
        end
    end

endmodule

`default_nettype wire

// ==== logic/ntt_pkg.sv ====
`default_nettype none

package ntt_pkg;

    // width of one residue or factor.
    localparam int D_WIDTH = 64;

    // lane 0 carries the c factor only; lanes 1 and up multiply.
    localparam int LANES = 8;

    // register stages inside one modular multiplier.
    localparam int MUL_LAT = 3;

    // one multiply stage is the multiplier plus its output register.
    localparam int STAGE_LAT = MUL_LAT + 1;

    // a*b first, then the product times c.
    localparam int PROC_LAT = 2 * STAGE_LAT;

    // one word, a residue or a factor.
    typedef logic [D_WIDTH-1:0] data_t;

    // full width product of two words.
    typedef logic [2*D_WIDTH-1:0] prod_t;

endpackage

`default_nettype wire

// ==== logic/twiddle_lane.sv ====
`default_nettype none

module twiddle_lane (
    input  wire            clk,
    input  wire            rst_n,
    input  wire ntt_pkg::data_t factor_a,
    input  wire ntt_pkg::data_t factor_b,
    input  wire ntt_pkg::data_t factor_c,
    input  wire ntt_pkg::data_t modulus,
    output ntt_pkg::data_t      twiddle
);

    // a*b mod n straight out of the first multiplier.
    ntt_pkg::data_t ab_mul;

    // a*b mod n after the stage output register.
    ntt_pkg::data_t ab_q;

    // c held back to line up with ab_q.
    ntt_pkg::data_t c_dly;

    // (a*b)*c mod n out of the second multiplier.
    ntt_pkg::data_t abc_mul;

    mod_mul u_mul_ab (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (factor_a),
        .b     (factor_b),
        .n     (modulus),
        .p     (ab_mul)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ab_q <= '0;
        end else begin
            ab_q <= ab_mul;
        end
    end

    // same depth as the first multiply stage.
    delay_line #(
        .DEPTH (ntt_pkg::STAGE_LAT)
    ) u_c_align (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (factor_c),
        .q     (c_dly)
    );

    mod_mul u_mul_c (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (ab_q),
        .b     (c_dly),
        .n     (modulus),
        .p     (abc_mul)
    );

    // second stage output register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            twiddle <= '0;
        end else begin
            twiddle <= abc_mul;
        end
    end

endmodule

`default_nettype wire

// ==== logic/twiddle_mul_process.sv ====
`default_nettype none

module twiddle_mul_process (
    input  wire            clk,
    input  wire            rst_n,
    input  wire ntt_pkg::data_t factor_a [1:ntt_pkg::LANES-1],
    input  wire ntt_pkg::data_t factor_b [1:ntt_pkg::LANES-1],
    input  wire ntt_pkg::data_t factor_c [0:ntt_pkg::LANES-1],
    input  wire ntt_pkg::data_t modulus,
    output wire ntt_pkg::data_t twiddle  [0:ntt_pkg::LANES-1]
);

    // lane 0 has no product, its c factor only waits out the
    // full datapath latency so all lanes stay in step.
    delay_line #(
        .DEPTH (ntt_pkg::PROC_LAT)
    ) u_lane0_bypass (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (factor_c[0]),
        .q     (twiddle[0])
    );

    // lanes 1 and up form ((a*b mod n)*c) mod n.
    for (genvar k = 1; k < ntt_pkg::LANES; k++) begin : g_lane
        twiddle_lane u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .factor_a (factor_a[k]),
            .factor_b (factor_b[k]),
            .factor_c (factor_c[k]),
            .modulus  (modulus),
            .twiddle  (twiddle[k])
        );
    end

endmodule

`default_nettype wire

// ==== test/twiddle_vectors.svh ====
`ifndef TWIDDLE_VECTORS_SVH
`define TWIDDLE_VECTORS_SVH

`default_nettype none

localparam int N_ROWS = 24;

// first row of the modulus 1 group and of the random modulus group.
localparam int GROUP_ONE = 10;
localparam int GROUP_RAND = 18;

// a common NTT prime, 2^64 - 2^32 + 1.
localparam ntt_pkg::data_t PRIME_N = 64'hFFFF_FFFF_0000_0001;

// one row of the table; a and b of lane 0 stay zero.
typedef struct packed {
    ntt_pkg::data_t n;
    ntt_pkg::data_t [ntt_pkg::LANES-1:0] a;
    ntt_pkg::data_t [ntt_pkg::LANES-1:0] b;
    ntt_pkg::data_t [ntt_pkg::LANES-1:0] c;
    ntt_pkg::data_t [ntt_pkg::LANES-1:0] expected;
} vec_row_t;

// ((a*b mod n)*c) mod n; ab is below n, so ab*c fits in 128 bits.
function automatic ntt_pkg::data_t model_twiddle(
    input ntt_pkg::data_t a,
    input ntt_pkg::data_t b,
    input ntt_pkg::data_t c,
    input ntt_pkg::data_t n
);
    ntt_pkg::prod_t ab;
    ntt_pkg::prod_t abc;
    ab = (ntt_pkg::prod_t'(a) * ntt_pkg::prod_t'(b)) % ntt_pkg::prod_t'(n);
    abc = (ab * ntt_pkg::prod_t'(c)) % ntt_pkg::prod_t'(n);
    return ntt_pkg::data_t'(abc);
endfunction

function automatic vec_row_t make_row(
    input int r,
    input ntt_pkg::data_t n_rand
);
    vec_row_t row;
    ntt_pkg::data_t n;
    row = '0;
    if (r < GROUP_ONE) begin
        n = PRIME_N;
    end else if (r < GROUP_RAND) begin
        n = 64'd1;
    end else begin
        n = n_rand;
    end
    row.n = n;
    for (int k = 0; k < ntt_pkg::LANES; k++) begin
        row.c[k] = {$urandom(), $urandom()};
        if (k > 0) begin
            row.a[k] = {$urandom(), $urandom()};
            row.b[k] = {$urandom(), $urandom()};
        end
    end
    if (r == 0 || r == GROUP_RAND) begin
        // zeros, n-1 and small values spread over the lanes.
        row.c[0] = n - 64'd1;
        for (int k = 1; k < ntt_pkg::LANES; k++) begin
            case (k % 4)
                0: begin
                    row.a[k] = '0;
                    row.b[k] = n - 64'd1;
                    row.c[k] = n - 64'd1;
                end
                1: begin
                    row.a[k] = '0;
                    row.b[k] = '0;
                    row.c[k] = '0;
                end
                2: begin
                    row.a[k] = n - 64'd1;
                    row.b[k] = n - 64'd1;
                    row.c[k] = n - 64'd1;
                end
                default: begin
                    row.a[k] = 64'd1;
                    row.b[k] = n - 64'd1;
                    row.c[k] = 64'd1;
                end
            endcase
        end
    end else if (r == 1 || r == GROUP_RAND + 1) begin
        // factors at or above n; n+k may wrap for a large random n.
        row.c[0] = n;
        for (int k = 1; k < ntt_pkg::LANES; k++) begin
            row.a[k] = n + ntt_pkg::data_t'(k);
            row.b[k] = n;
            row.c[k] = ~ntt_pkg::data_t'(k);
        end
    end
    row.expected[0] = row.c[0];
    for (int k = 1; k < ntt_pkg::LANES; k++) begin
        row.expected[k] = model_twiddle(row.a[k], row.b[k], row.c[k], n);
    end
    return row;
endfunction

`default_nettype wire

`endif

// ==== test/twiddle_tb.sv ====
`include "twiddle_vectors.svh"

`default_nettype none

module twiddle_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 8;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + N_ROWS + ntt_pkg::PROC_LAT + 20;

    logic clk;
    logic rst_n;
    ntt_pkg::data_t factor_a [1:ntt_pkg::LANES-1];
    ntt_pkg::data_t factor_b [1:ntt_pkg::LANES-1];
    ntt_pkg::data_t factor_c [0:ntt_pkg::LANES-1];
    ntt_pkg::data_t modulus;
    ntt_pkg::data_t twiddle  [0:ntt_pkg::LANES-1];

    vec_row_t vec_table [0:N_ROWS-1];

    // set when the modulus stays put for the whole flight of the row.
    bit settled [0:N_ROWS-1];

    int checks_done = 0;
    int checks_expected = 0;
    int cycle_count = 0;

    twiddle_mul_process UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .factor_a (factor_a),
        .factor_b (factor_b),
        .factor_c (factor_c),
        .modulus  (modulus),
        .twiddle  (twiddle)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic check_value(
        input string name,
        input int lane,
        input ntt_pkg::data_t expected,
        input ntt_pkg::data_t actual
    );
        checks_done++;
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s[%0d] expected=%h actual=%h",
                     $time, name, lane, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "twiddle output differs from the model");
        end
    endtask

    task automatic build_table();
        ntt_pkg::data_t n_rand;
        n_rand = {$urandom(), $urandom()};
        if (n_rand == '0) begin
            n_rand = 64'd3;
        end
        for (int r = 0; r < N_ROWS; r++) begin
            vec_table[r] = make_row(r, n_rand);
        end
        // a row sees the modulus of the next PROC_LAT-1 rows while in flight.
        for (int r = 0; r < N_ROWS; r++) begin
            settled[r] = 1'b1;
            for (int j = r + 1; j < r + ntt_pkg::PROC_LAT && j < N_ROWS; j++) begin
                if (vec_table[j].n != vec_table[r].n) begin
                    settled[r] = 1'b0;
                end
            end
        end
        checks_expected = ntt_pkg::LANES * ntt_pkg::PROC_LAT;
        for (int r = 0; r < N_ROWS; r++) begin
            checks_expected += settled[r] ? ntt_pkg::LANES : 1;
        end
    endtask

    task automatic drive_row(input int r);
        modulus = vec_table[r].n;
        factor_c[0] = vec_table[r].c[0];
        for (int k = 1; k < ntt_pkg::LANES; k++) begin
            factor_a[k] = vec_table[r].a[k];
            factor_b[k] = vec_table[r].b[k];
            factor_c[k] = vec_table[r].c[k];
        end
    endtask

    task automatic clear_inputs();
        modulus = '0;
        factor_c[0] = '0;
        for (int k = 1; k < ntt_pkg::LANES; k++) begin
            factor_a[k] = '0;
            factor_b[k] = '0;
            factor_c[k] = '0;
        end
    endtask

    // nothing has reached the output yet.
    task automatic check_idle();
        for (int k = 0; k < ntt_pkg::LANES; k++) begin
            check_value("twiddle", k, '0, twiddle[k]);
        end
    endtask

    task automatic check_row(input int r);
        check_value("twiddle", 0, vec_table[r].expected[0], twiddle[0]);
        if (settled[r]) begin
            for (int k = 1; k < ntt_pkg::LANES; k++) begin
                check_value("twiddle", k, vec_table[r].expected[k], twiddle[k]);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        void'($urandom(32'h3cfc));
        build_table();

        // real factors sit on the inputs while reset holds every register.
        drive_row(N_ROWS - 1);

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // only zeros enter before the first row, so the idle window shows reset values.
        clear_inputs();

        // one row per falling edge; results are due PROC_LAT edges later.
        for (int i = 0; i < N_ROWS + ntt_pkg::PROC_LAT; i++) begin
            @(negedge clk);
            if (i < ntt_pkg::PROC_LAT) begin
                check_idle();
            end else begin
                check_row(i - ntt_pkg::PROC_LAT);
            end
            if (i < N_ROWS) begin
                drive_row(i);
            end
        end

        if (checks_done == checks_expected) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("wrong number of checks: %0d run, %0d expected",
                     checks_done, checks_expected);
            $display("*** FAILED ***");
            $fatal(1, "check count does not match the table");
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+test
logic/ntt_pkg.sv
logic/mod_mul.sv
logic/delay_line.sv
logic/twiddle_lane.sv
logic/twiddle_mul_process.sv
test/twiddle_tb.sv
